// ==== hw/arb_consts.svh ====
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// sizing of the four port packet arbiter multiplexer

// number of input ports that compete for the single output
`define ARB_PORTS 4

// payload bits carried by one frame word
`define ARB_DATA_WIDTH 16

// words held by each per-port queue, kept a power of two so pointers wrap
`define ARB_FIFO_DEPTH 16

// bits needed for a port index, must match the port count above
`define ARB_PORT_W 2

`endif

// ==== hw/frame_pkg.sv ====
`include "arb_consts.svh"

// frame level types that travel from the input ports to the output
package frame_pkg;

    // one word of a frame as it sits in a queue or leaves the mover
    typedef struct packed {
        logic                       last; // marks the final word of a frame
        logic [`ARB_DATA_WIDTH-1:0] data; // payload, passed through untouched
    } frame_word_t;

endpackage

// ==== hw/arb_pkg.sv ====
`include "arb_consts.svh"

// types that describe arbitration and the frame mover control
package arb_pkg;

    // registered grant as the arbiter hands it to the mover
    typedef struct packed {
        logic                   valid; // a port currently owns the output
        logic [`ARB_PORTS-1:0]  mask;  // one-hot copy of the winning port
        logic [`ARB_PORT_W-1:0] index; // encoded winning port
    } grant_t;

    // mover states, one frame is carried per pass through the loop
    typedef enum logic [1:0] {
        st_idle     = 2'd0, // wait for a valid grant
        st_transfer = 2'd1, // pop one word of the granted queue per cycle
        st_release  = 2'd2  // let the arbiter settle after the acknowledge
    } mover_state_t;

endpackage

// ==== hw/priority_encoder.sv ====
`include "arb_consts.svh"

module priority_encoder #(
    parameter bit lsb_high_priority = 1'b0 // bit 0 wins when set, else the top bit wins
) (
    input  logic [`ARB_PORTS-1:0]  unencoded,
    output logic                   encoded_valid,
    output logic [`ARB_PORT_W-1:0] encoded,
    output logic [`ARB_PORTS-1:0]  one_hot
);

    localparam int port_w = `ARB_PORT_W;

    // the scan runs from the lowest priority end toward the highest one
    // so the last hit that is recorded is the winner
    always_comb begin
        int idx;
        encoded = '0;
        for (int i = 0; i < `ARB_PORTS; i++) begin
            if (lsb_high_priority) begin
                idx = `ARB_PORTS - 1 - i; // walk down so bit 0 is seen last
            end else begin
                idx = i; // walk up so the top bit is seen last
            end
            if (unencoded[idx]) begin
                encoded = port_w'(idx);
            end
        end
    end

    assign encoded_valid = |unencoded; // any request at all

    // one-hot form of the winner, all zero when nothing requests
    always_comb begin
        one_hot = '0;
        if (encoded_valid) begin
            one_hot[encoded] = 1'b1;
        end
    end

endmodule

// ==== hw/arbiter.sv ====
`include "arb_consts.svh"

module arbiter
    import arb_pkg::*;
#(
    parameter bit round_robin       = 1'b0, // rotate priority after every grant
    parameter bit lsb_high_priority = 1'b0  // port 0 has the top fixed priority
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ARB_PORTS-1:0] request,
    input  logic [`ARB_PORTS-1:0] acknowledge,
    output grant_t                grant
);

    grant_t                 grant_next;
    logic [`ARB_PORTS-1:0]  mask_reg;       // ports that still outrank the last winner
    logic [`ARB_PORTS-1:0]  mask_next;
    logic [`ARB_PORTS-1:0]  live_request;
    logic [`ARB_PORTS-1:0]  masked_request;
    logic                   raw_valid;
    logic [`ARB_PORT_W-1:0] raw_index;
    logic [`ARB_PORTS-1:0]  raw_one_hot;
    logic                   masked_valid;
    logic [`ARB_PORT_W-1:0] masked_index;
    logic [`ARB_PORTS-1:0]  masked_one_hot;

    // the queue being acknowledged still shows its old frame count this cycle
    // so its request is ignored until the count has caught up
    assign live_request   = request & ~acknowledge;
    assign masked_request = live_request & mask_reg; // only ports past the last winner

    priority_encoder #(
        .lsb_high_priority(lsb_high_priority)
    ) raw_enc_i (
        .unencoded    (live_request),
        .encoded_valid(raw_valid),
        .encoded      (raw_index),
        .one_hot      (raw_one_hot)
    );

    priority_encoder #(
        .lsb_high_priority(lsb_high_priority)
    ) masked_enc_i (
        .unencoded    (masked_request),
        .encoded_valid(masked_valid),
        .encoded      (masked_index),
        .one_hot      (masked_one_hot)
    );

    // mask that leaves the winner and everything above it in priority out
    function automatic logic [`ARB_PORTS-1:0] rotate_mask(
        input logic [`ARB_PORT_W-1:0] index
    );
        logic [`ARB_PORTS-1:0] ones;
        ones = '1;
        if (lsb_high_priority) begin
            return ones << (int'(index) + 1); // higher ports go first next time
        end else begin
            return ones >> (`ARB_PORTS - int'(index)); // lower ports go first next time
        end
    endfunction

    always_comb begin
        grant_next = '0; // no request means no grant
        mask_next  = mask_reg;
        if (grant.valid && !(|(grant.mask & acknowledge))) begin
            grant_next = grant; // frame still moving so the owner keeps the output
        end else if (round_robin && masked_valid) begin
            grant_next.valid = 1'b1; // someone past the last winner is waiting
            grant_next.mask  = masked_one_hot;
            grant_next.index = masked_index;
            mask_next        = rotate_mask(masked_index);
        end else if (raw_valid) begin
            grant_next.valid = 1'b1; // wrap around to the plain priority order
            grant_next.mask  = raw_one_hot;
            grant_next.index = raw_index;
            if (round_robin) begin
                mask_next = rotate_mask(raw_index);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant    <= '0;
            mask_reg <= '0; // empty mask so the first pick uses plain priority
        end else begin
            grant    <= grant_next;
            mask_reg <= mask_next;
        end
    end

endmodule

// ==== hw/frame_fifo.sv ====
`include "arb_consts.svh"

module frame_fifo
    import frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_valid,
    input  frame_word_t wr_word,
    input  logic        rd_pop,
    output frame_word_t head,
    output logic        full,
    output logic        request
);

    localparam int addr_w = $clog2(`ARB_FIFO_DEPTH);
    localparam logic [addr_w:0] depth_count = `ARB_FIFO_DEPTH;

    frame_word_t       mem [`ARB_FIFO_DEPTH]; // word storage
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   word_count;  // words held from 0 up to the full depth
    logic [addr_w:0]   frame_count; // complete frames held
    logic              do_write;
    logic              do_read;

    assign full     = (word_count == depth_count);
    assign do_write = wr_valid && !full;          // a word into a full queue is lost
    assign do_read  = rd_pop && (word_count != '0); // an empty queue ignores the pop
    assign head     = mem[rd_ptr];                // oldest word shown without a read delay
    assign request  = (frame_count != '0);        // ask only once a whole frame is in

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            word_count  <= '0;
            frame_count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two so it wraps
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   word_count <= word_count + 1'b1;
                2'b01:   word_count <= word_count - 1'b1;
                default: word_count <= word_count; // both or neither leave it alone
            endcase
            // a frame is counted when its last word goes in and dropped when it leaves
            case ({do_write && wr_word.last, do_read && head.last})
                2'b10:   frame_count <= frame_count + 1'b1;
                2'b01:   frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;
            endcase
        end
    end

endmodule

// ==== hw/frame_mux.sv ====
`include "arb_consts.svh"

module frame_mux
    import frame_pkg::*;
    import arb_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  grant_t                 grant,
    input  frame_word_t            heads [`ARB_PORTS],
    output logic [`ARB_PORTS-1:0]  pop,
    output logic [`ARB_PORTS-1:0]  acknowledge,
    output logic                   out_valid,
    output frame_word_t            out_word,
    output logic [`ARB_PORT_W-1:0] out_port
);

    mover_state_t state;
    mover_state_t state_next;
    frame_word_t  sel_word; // head of the queue that owns the output

    assign sel_word = heads[grant.index];

    always_comb begin
        state_next  = state;
        pop         = '0;
        acknowledge = '0;
        case (state)
            st_idle: begin
                if (grant.valid) begin
                    state_next = st_transfer; // start popping in the next cycle
                end
            end
            st_transfer: begin
                pop = grant.mask; // one word leaves the granted queue per cycle
                if (sel_word.last) begin
                    acknowledge = grant.mask; // frees the arbiter with the final pop
                    state_next  = st_release;
                end
            end
            st_release: begin
                state_next = st_idle; // one cycle for the grant to refresh
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            out_valid <= (state == st_transfer); // one cycle behind each pop
        end
    end

    // output word and source port follow the pop that produced them
    always_ff @(posedge clk) begin
        if (state == st_transfer) begin
            out_word <= sel_word;
            out_port <= grant.index;
        end
    end

endmodule

// ==== hw/arb_mux_top.sv ====
`include "arb_consts.svh"

module arb_mux_top
    import frame_pkg::*;
    import arb_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`ARB_PORTS-1:0]  in_valid,
    input  frame_word_t            in_word [`ARB_PORTS],
    output logic [`ARB_PORTS-1:0]  in_full,
    output logic                   out_valid,
    output frame_word_t            out_word,
    output logic [`ARB_PORT_W-1:0] out_port
);

    logic [`ARB_PORTS-1:0] request;     // one bit per queue with a whole frame ready
    logic [`ARB_PORTS-1:0] pop;         // one-hot read strobe from the mover
    logic [`ARB_PORTS-1:0] acknowledge; // one-hot end of frame pulse to the arbiter
    frame_word_t           heads [`ARB_PORTS];
    grant_t                grant;

    // one queue per input port
    for (genvar i = 0; i < `ARB_PORTS; i++) begin : g_port
        frame_fifo fifo_i (
            .clk     (clk),
            .rst     (rst),
            .wr_valid(in_valid[i]),
            .wr_word (in_word[i]),
            .rd_pop  (pop[i]),
            .head    (heads[i]),
            .full    (in_full[i]),
            .request (request[i])
        );
    end

    // round robin with port 0 first after reset
    arbiter #(
        .round_robin      (1'b1),
        .lsb_high_priority(1'b1)
    ) arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .request    (request),
        .acknowledge(acknowledge),
        .grant      (grant)
    );

    frame_mux frame_mux_i (
        .clk        (clk),
        .rst        (rst),
        .grant      (grant),
        .heads      (heads),
        .pop        (pop),
        .acknowledge(acknowledge),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_port   (out_port)
    );

endmodule

// ==== test/tb_arb_mux_top.sv ====
`include "arb_consts.svh"

module tb_arb_mux_top
    import frame_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 500;
    localparam int quiet_cycles   = 8; // well past the 4 cycle latency and the frame gap

    logic                   clk;
    logic                   rst;
    logic [`ARB_PORTS-1:0]  in_valid;
    frame_word_t            in_word [`ARB_PORTS];
    logic [`ARB_PORTS-1:0]  in_full;
    logic                   out_valid;
    frame_word_t            out_word;
    logic [`ARB_PORT_W-1:0] out_port;

    frame_word_t            exp_q [`ARB_PORTS][$]; // expected words per source port in write order
    int                     served_ports [$];      // source port of each frame in output order
    int                     errors;
    int                     cycle = 0;             // rising edges seen so far
    int                     last_write_cycle;      // cycle in which the latest last word was driven
    int                     frame_start_cycle;     // cycle of the first word of the latest frame
    logic                   in_frame;              // an output frame has started but not ended
    logic [`ARB_PORT_W-1:0] cur_port;
    logic [31:0]            lfsr_state;

    arb_mux_top arb_mux_top_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_word  (in_word),
        .in_full  (in_full),
        .out_valid(out_valid),
        .out_word (out_word),
        .out_port (out_port)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk; // 40 ns period

    always @(posedge clk) cycle <= cycle + 1;

    // output scoreboard that samples on the falling edge where the outputs are settled
    always @(negedge clk) begin
        frame_word_t exp_word;
        if (!rst) begin
            if (out_valid) begin
                if (in_frame && out_port != cur_port) begin
                    errors++;
                    $display("ERR %0t: frame from port %0d split by a word from port %0d",
                             $time, cur_port, out_port);
                end
                if (!in_frame) begin
                    served_ports.push_back(int'(out_port)); // first word of a new frame
                    frame_start_cycle = cycle;
                end
                if (exp_q[out_port].size() == 0) begin
                    errors++;
                    $display("ERR %0t: unexpected word %h from port %0d",
                             $time, out_word, out_port);
                end else begin
                    exp_word = exp_q[out_port].pop_front();
                    if (out_word != exp_word) begin
                        errors++;
                        $display("ERR %0t: port %0d gave word %h, expected %h",
                                 $time, out_port, out_word, exp_word);
                    end
                end
                in_frame = !out_word.last; // the frame ends with its last flag
                cur_port = out_port;
            end else if (in_frame) begin
                errors++;
                $display("ERR %0t: gap inside a frame from port %0d", $time, cur_port);
            end
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b          = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003; // taps 32, 22, 2 and 1
        end
        return b;
    endfunction

    function automatic logic [`ARB_DATA_WIDTH-1:0] random_data();
        logic [`ARB_DATA_WIDTH-1:0] data;
        data = '0;
        for (int i = 0; i < `ARB_DATA_WIDTH; i++) begin
            data = {data[`ARB_DATA_WIDTH-2:0], lfsr_bit()};
        end
        return data;
    endfunction

    // moves to 5 ns after the next rising edge and clears the write strobes
    task automatic step();
        @(posedge clk);
        #5;
        in_valid = '0;
    endtask

    // sets up one word on a port for the coming edge; keep means the queue will accept it
    task automatic set_word(input int port, input logic last, input logic keep);
        frame_word_t word;
        word.last      = last;
        word.data      = random_data();
        in_valid[port] = 1'b1;
        in_word[port]  = word;
        if (keep) begin
            exp_q[port].push_back(word);
        end
        if (last) begin
            last_write_cycle = cycle;
        end
    endtask

    task automatic send_frame(input int port, input int len);
        for (int i = 0; i < len; i++) begin
            set_word(port, i == len - 1, 1'b1);
            step();
        end
    endtask

    task automatic reset_dut();
        rst      = 1'b1;
        in_valid = '0;
        step();
        step(); // reset seen on two rising edges
        rst      = 1'b0;
        in_frame = 1'b0;
        served_ports.delete();
        for (int p = 0; p < `ARB_PORTS; p++) begin
            exp_q[p].delete();
        end
    endtask

    task automatic wait_frames(input int count, input string what);
        int n;
        n = 0;
        while (served_ports.size() < count && n < timeout_cycles) begin
            step();
            n++;
        end
        if (served_ports.size() < count) begin
            errors++;
            $display("timeout: %s saw no frame start within %0d cycles", what, timeout_cycles);
        end
    endtask

    task automatic wait_drain(input string what);
        int   n;
        logic busy;
        n    = 0;
        busy = 1'b1;
        while (busy && n < timeout_cycles) begin
            step();
            n++;
            busy = in_frame;
            for (int p = 0; p < `ARB_PORTS; p++) begin
                if (exp_q[p].size() != 0) begin
                    busy = 1'b1; // words still owed by this port
                end
            end
        end
        if (busy) begin
            errors++;
            $display("timeout: %s output did not drain within %0d cycles", what, timeout_cycles);
        end else begin
            // any stray word shows up at the scoreboard within a few frame gaps
            for (int i = 0; i < quiet_cycles; i++) begin
                step();
            end
        end
    endtask

    task automatic single_frame_test();
        reset_dut();
        for (int i = 0; i < 4; i++) begin
            step();
            if (out_valid) begin
                errors++;
                $display("ERR %0t: out_valid high with nothing written", $time);
            end
        end
        send_frame(2, 3);
        wait_frames(1, "single frame");
        if (served_ports.size() > 0 && served_ports[0] != 2) begin
            errors++;
            $display("ERR %0t: frame served from port %0d, expected 2", $time, served_ports[0]);
        end
        if (frame_start_cycle - last_write_cycle != 4) begin
            errors++;
            $display("ERR %0t: first word %0d cycles after the last write, expected 4",
                     $time, frame_start_cycle - last_write_cycle);
        end
        wait_drain("single frame");
    endtask

    task automatic port_order_test();
        reset_dut();
        send_frame(0, 2);
        send_frame(0, 5); // the flat per-port queue checks order and mixing
        wait_drain("port order");
        if (served_ports.size() != 2) begin
            errors++;
            $display("ERR %0t: %0d frames served, expected 2", $time, served_ports.size());
        end
    endtask

    task automatic round_robin_test();
        reset_dut();
        // all ports written in lockstep so each batch of last words lands in one cycle
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < 3; i++) begin
                for (int p = 0; p < `ARB_PORTS; p++) begin
                    set_word(p, i == 2, 1'b1);
                end
                step();
            end
        end
        wait_drain("round robin");
        if (served_ports.size() != 2 * `ARB_PORTS) begin
            errors++;
            $display("ERR %0t: %0d frames served, expected 8", $time, served_ports.size());
        end else begin
            for (int i = 0; i < 2 * `ARB_PORTS; i++) begin
                if (served_ports[i] != i % `ARB_PORTS) begin
                    errors++;
                    $display("ERR %0t: frame %0d from port %0d, expected %0d",
                             $time, i, served_ports[i], i % `ARB_PORTS);
                end
            end
        end
    endtask

    task automatic interleave_test();
        reset_dut();
        send_frame(1, 8);
        wait_frames(1, "interleave"); // port 1 now owns the output
        for (int i = 0; i < 6; i++) begin
            set_word(0, i == 2 || i == 5, 1'b1);          // two frames of 3
            set_word(2, i == 5, 1'b1);                    // one frame of 6
            set_word(3, i == 1 || i == 3 || i == 5, 1'b1); // three frames of 2
            step();
        end
        wait_drain("interleave");
        if (served_ports.size() != 7) begin
            errors++;
            $display("ERR %0t: %0d frames served, expected 7", $time, served_ports.size());
        end
    endtask

    task automatic full_level_test();
        int                    held;
        logic                  keep;
        logic [`ARB_PORTS-1:0] exp_full;
        reset_dut();
        held = 0; // queue is empty and nothing pops until the frame is complete
        // the word that fills the queue closes the frame so that the queue can drain
        for (int i = 0; i <= `ARB_FIFO_DEPTH; i++) begin
            exp_full    = '0;
            exp_full[3] = (held == `ARB_FIFO_DEPTH); // the other queues stay empty
            if (in_full != exp_full) begin
                errors++;
                $display("ERR %0t: in_full is %b with %0d words held on port 3",
                         $time, in_full, held);
            end
            keep = (held < `ARB_FIFO_DEPTH); // a word into a full queue is dropped
            set_word(3, i >= `ARB_FIFO_DEPTH - 1, keep);
            if (keep) begin
                held++;
            end
            step();
        end
        wait_drain("full level");
        if (served_ports.size() != 1) begin
            errors++;
            $display("ERR %0t: %0d frames served, expected 1", $time, served_ports.size());
        end
    endtask

    initial begin
        errors     = 0;
        lfsr_state = 32'h0e20_626d;
        rst        = 1'b1;
        in_valid   = '0;
        in_frame   = 1'b0;
        cur_port   = '0;
        for (int p = 0; p < `ARB_PORTS; p++) begin
            in_word[p] = '0;
        end
        single_frame_test();
        port_order_test();
        round_robin_test();
        interleave_test();
        full_level_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== arb_mux_top.f ====
+incdir+hw
hw/frame_pkg.sv
hw/arb_pkg.sv
hw/priority_encoder.sv
hw/arbiter.sv
hw/frame_fifo.sv
hw/frame_mux.sv
hw/arb_mux_top.sv
test/tb_arb_mux_top.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_arb_mux_top
FILELIST := arb_mux_top.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

# build, run, and decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	$(BUILD)/$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
